// File: Bender.yml
package:
  name: eth_tx

export_include_dirs:
  - verilog

sources:
  # Transmit MAC, package first
  - include_dirs:
      - verilog
    files:
      - verilog/eth_tx_pkg.sv
      - verilog/eth_tx_framer.sv
      - verilog/eth_crc32.sv
      - verilog/eth_tx_out_stage.sv
      - verilog/eth_tx_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/eth_tx_tb.sv

// File: compile.f
+incdir+verilog
verilog/eth_tx_pkg.sv
verilog/eth_tx_framer.sv
verilog/eth_crc32.sv
verilog/eth_tx_out_stage.sv
verilog/eth_tx_top.sv
testbench/eth_tx_tb.sv

// File: testbench/eth_tx_tb.sv
`include "eth_tx_defs.svh"

module eth_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table, one entry per frame
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [8:0]               len;     // Payload bytes
        eth_tx_pkg::link_speed_t  speed;   // Gap after this frame
        logic                     stall;   // Random phy_ready drops
        logic                     reuse;   // Resend previous payload
    } frame_cfg_t;

    localparam int num_frames = 9;

    frame_cfg_t frames [num_frames] = '{
        '{len: 9'd1,   speed: 2'b10, stall: 1'b0, reuse: 1'b0},   // Mostly padding
        '{len: 9'd45,  speed: 2'b10, stall: 1'b0, reuse: 1'b0},
        '{len: 9'd45,  speed: 2'b10, stall: 1'b1, reuse: 1'b1},   // Same bytes, stalled
        '{len: 9'd59,  speed: 2'b01, stall: 1'b0, reuse: 1'b0},   // One pad byte
        '{len: 9'd60,  speed: 2'b11, stall: 1'b0, reuse: 1'b0},   // Exactly minimum
        '{len: 9'd61,  speed: 2'b00, stall: 1'b1, reuse: 1'b0},
        '{len: 9'd200, speed: 2'b10, stall: 1'b0, reuse: 1'b0},
        '{len: 9'd200, speed: 2'b10, stall: 1'b1, reuse: 1'b1},
        '{len: 9'd1,   speed: 2'b11, stall: 1'b1, reuse: 1'b0}
    };

    logic                     clk;
    logic                     reset_n;
    eth_tx_pkg::eth_byte_t    payload_data;
    logic                     payload_valid;
    logic                     payload_last;
    logic                     payload_ready;
    logic                     phy_ready;
    eth_tx_pkg::eth_byte_t    tx_data;
    logic                     tx_dv;
    eth_tx_pkg::link_speed_t  link_speed;
    logic                     stall_en;      // phy_ready drops allowed

    eth_tx_pkg::eth_byte_t    pl_q[$];       // Current payload
    eth_tx_pkg::eth_byte_t    exp_q[$];      // Model frame
    eth_tx_pkg::eth_byte_t    rx_q[$];       // Bytes taken off the PHY bus
    eth_tx_pkg::eth_byte_t    cur_q[$];      // Frame just checked
    eth_tx_pkg::eth_byte_t    clean_q[$];    // Last frame sent without stalls
    eth_tx_pkg::ifg_count_t   gap_q[$];      // Low run before each new burst
    int                       gap_run;       // Advancing cycles with tx_dv low
    bit                       dv_prev;       // tx_dv at the last advancing cycle
    int                       bursts;        // tx_dv bursts seen
    int                       strobe_total;  // payload_ready strobes so far
    int                       errors;
    int                       checks;

    eth_tx_top eth_tx_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .payload_ready (payload_ready),
        .phy_ready     (phy_ready),
        .tx_data       (tx_data),
        .tx_dv         (tx_dv),
        .link_speed    (link_speed)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // 96 bit times per speed code, in byte clocks
    function automatic eth_tx_pkg::ifg_count_t gap_for_speed(input eth_tx_pkg::link_speed_t s);
        eth_tx_pkg::ifg_count_t g;
        case (s)
            2'b00:   g = `ETH_IFG_10M;
            2'b01:   g = `ETH_IFG_100M;
            default: g = `ETH_IFG_GBIT;
        endcase
        return g;
    endfunction

    // Serial LFSR form, one wire bit per call
    function automatic eth_tx_pkg::crc_t crc_shift(input eth_tx_pkg::crc_t c, input logic d);
        eth_tx_pkg::crc_t r;
        r = (c >> 1) ^ (`ETH_CRC_POLY & {32{c[0] ^ d}});
        return r;
    endfunction

    function automatic string region_of(input int idx, input int n);
        string r;
        if (idx < 7) r = "preamble";
        else if (idx == 7) r = "sfd";
        else if (idx < 8 + n) r = "payload";
        else if (idx < 8 + ((n < `ETH_MIN_FRAME) ? `ETH_MIN_FRAME : n)) r = "pad";
        else r = "fcs";
        return r;
    endfunction

    task automatic build_expected(input int n);
        eth_tx_pkg::crc_t      crc;
        eth_tx_pkg::eth_byte_t b;
        int                    body;
        exp_q.delete();
        crc  = `ETH_CRC_INIT;
        body = (n < `ETH_MIN_FRAME) ? `ETH_MIN_FRAME : n;   // Payload plus pad
        repeat (7) exp_q.push_back(`ETH_PREAMBLE_BYTE);
        exp_q.push_back(`ETH_SFD_BYTE);
        for (int i = 0; i < body; i++) begin
            b = (i < n) ? pl_q[i] : `ETH_PAD_BYTE;
            exp_q.push_back(b);
            for (int j = 0; j < 8; j++) crc = crc_shift(crc, b[j]);   // LSB first
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) exp_q.push_back(crc[8*i +: 8]);    // Low byte first
    endtask

    task automatic check_byte(input string name, input eth_tx_pkg::eth_byte_t exp,
                              input eth_tx_pkg::eth_byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input eth_tx_pkg::ifg_count_t exp,
                               input eth_tx_pkg::ifg_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, PHY back-pressure, source and monitor
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        phy_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            phy_ready = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;  // ~1 in 4 stalled
        end
    end

    // One byte per strobe, next byte shown right after the consuming edge
    task automatic serve_payload(input int n);
        int   idx;
        logic took;
        idx = 0;
        @(posedge clk);
        #1;
        payload_valid = 1'b1;
        payload_data  = pl_q[0];
        payload_last  = (n == 1);
        while (idx < n) begin
            @(negedge clk);
            took = payload_ready;             // Settled mid-cycle
            @(posedge clk);
            #1;
            if (took) begin
                idx++;
                payload_data  = (idx < n) ? pl_q[idx] : '0;
                payload_last  = (idx == n - 1);
                payload_valid = (idx < n);    // Drops after the last byte
            end
        end
    endtask

    // Transfers and gap lengths, counted on advancing cycles only
    always @(negedge clk) begin
        if (!reset_n) begin
            if (payload_ready) strobe_total++;
            if (phy_ready) begin
                if (tx_dv) begin
                    if (!dv_prev && bursts > 0) gap_q.push_back(eth_tx_pkg::ifg_count_t'(gap_run));
                    if (!dv_prev) bursts++;
                    rx_q.push_back(tx_data);
                    gap_run = 0;
                end else begin
                    gap_run++;
                end
                dv_prev = tx_dv;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        int                      n;
        int                      strobe_base;
        eth_tx_pkg::link_speed_t prev_speed;
        payload_data  = '0;
        payload_valid = 1'b0;
        payload_last  = 1'b0;
        link_speed    = 2'b10;
        stall_en      = 1'b0;
        reset_n       = 1'b1;                 // In reset while high
        errors        = 0;
        checks        = 0;
        prev_speed    = 2'b10;
        void'($urandom(32'h1513_aff4));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b0;

        for (int k = 0; k < num_frames; k++) begin
            n = frames[k].len;
            if (!frames[k].reuse) begin
                pl_q.delete();
                repeat (n) pl_q.push_back(eth_tx_pkg::eth_byte_t'($urandom_range(0, 255)));
            end
            build_expected(n);
            @(posedge clk);
            #1;
            link_speed  = frames[k].speed;
            stall_en    = frames[k].stall;
            strobe_base = strobe_total;
            fork
                serve_payload(n);
                while (rx_q.size() < exp_q.size()) @(posedge clk);
            join

            cur_q.delete();
            for (int i = 0; i < exp_q.size(); i++) begin
                cur_q.push_back(rx_q.pop_front());
                check_byte($sformatf("frame %0d %s byte %0d", k, region_of(i, n), i),
                           exp_q[i], cur_q[i]);
            end
            check_count($sformatf("frame %0d payload strobes", k),
                        eth_tx_pkg::ifg_count_t'(n),
                        eth_tx_pkg::ifg_count_t'(strobe_total - strobe_base));

            // Next source is already waiting, so the gap is the minimum
            if (gap_q.size() != ((k > 0) ? 1 : 0)) begin
                errors++;
                $display("Frame %0d did not arrive as one unbroken tx_dv burst", k);
                gap_q.delete();
            end else if (k > 0) begin
                check_count($sformatf("gap before frame %0d", k),
                            gap_for_speed(prev_speed), gap_q.pop_front());
            end

            if (frames[k].reuse) begin
                foreach (cur_q[i]) begin
                    check_byte($sformatf("frame %0d stalled vs clean byte %0d", k, i),
                               clean_q[i], cur_q[i]);
                end
            end
            if (!frames[k].stall) clean_q = cur_q;
            prev_speed = frames[k].speed;
        end

        $display("Done: %0d frames, %0d checks, %0d errors", num_frames, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Budget per frame: 4 cycles a byte, the gap, and some slack
    initial begin : watchdog
        longint limit;
        int     bytes;
        limit = 0;
        foreach (frames[i]) begin
            bytes = 8 + ((frames[i].len < `ETH_MIN_FRAME) ? `ETH_MIN_FRAME : frames[i].len) + 4;
            limit += bytes * 4 + gap_for_speed(frames[i].speed) + 100;
        end
        #(limit * 10);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: verilog/eth_crc32.sv
`include "eth_tx_defs.svh"

module eth_crc32 (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   phy_ready,
    input  eth_tx_pkg::tx_slot_t   slot,
    output eth_tx_pkg::crc_t       fcs
);

    ////////////////////////////////////////////////////////////////////////////
    // Running reflected CRC-32
    ////////////////////////////////////////////////////////////////////////////

    eth_tx_pkg::crc_t crc_q;      // CRC register
    eth_tx_pkg::crc_t crc_next;   // Register after folding in the slot byte

    // One byte, LSB first, bit by bit against the reflected polynomial
    function automatic eth_tx_pkg::crc_t crc_byte(
        input eth_tx_pkg::crc_t      crc_in,
        input eth_tx_pkg::eth_byte_t data
    );
        eth_tx_pkg::crc_t c;
        c = crc_in ^ {24'h00_0000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, slot.data);

    // Slots are the framer's registered output, so this runs in step with it
    always_ff @(posedge clk) begin
        if (reset_n) begin
            crc_q <= `ETH_CRC_INIT;
        end else if (phy_ready) begin
            if (slot.sof) begin
                crc_q <= `ETH_CRC_INIT;      // New frame starts at the SFD
            end else if (slot.crc_en) begin
                crc_q <= crc_next;           // Payload and pad bytes only
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FCS output
    ////////////////////////////////////////////////////////////////////////////

    // Final complement; byte 0 = fcs[7:0] is the first on the wire.
    // Stable from the first FCS slot onwards, no data slots follow it
    assign fcs = ~crc_q;

endmodule

// File: verilog/eth_tx_defs.svh
`ifndef ETH_TX_DEFS_SVH
`define ETH_TX_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame framing bytes
////////////////////////////////////////////////////////////////////////////

`define ETH_PREAMBLE_BYTE 8'h55     // Seven of these open each frame
`define ETH_SFD_BYTE      8'hD5     // Start-of-frame delimiter
`define ETH_PAD_BYTE      8'h00     // Filler up to the minimum size

// Payload plus pad, FCS not counted
`define ETH_MIN_FRAME     60

// Inter-frame gap in 125 MHz clocks, 96 bit times per link speed
`define ETH_IFG_GBIT      11'd12
`define ETH_IFG_100M      11'd120
`define ETH_IFG_10M       11'd1200

////////////////////////////////////////////////////////////////////////////
// CRC-32, IEEE 802.3, LSB-first form
////////////////////////////////////////////////////////////////////////////

`define ETH_CRC_INIT      32'hFFFF_FFFF
`define ETH_CRC_POLY      32'hEDB8_8320  // 0x04C11DB7 bit-reversed

`endif

// File: verilog/eth_tx_framer.sv
`include "eth_tx_defs.svh"

module eth_tx_framer (
    input  logic                      clk,
    input  logic                      reset_n,
    input  eth_tx_pkg::eth_byte_t     payload_data,
    input  logic                      payload_valid,
    input  logic                      payload_last,
    input  logic                      phy_ready,
    input  eth_tx_pkg::link_speed_t   link_speed,
    output logic                      payload_ready,
    output eth_tx_pkg::tx_slot_t      slot
);

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencer state and counters
    ////////////////////////////////////////////////////////////////////////////

    eth_tx_pkg::framer_state_e  state;
    logic [2:0]                 byte_cnt;    // Preamble position / FCS index
    logic [5:0]                 size_cnt;    // Payload plus pad up to 60
    logic [5:0]                 size_next;   // Size after this slot
    logic                       size_done;   // This slot reaches the minimum
    eth_tx_pkg::ifg_count_t     ifg_cnt;     // Cycles spent in GAP
    eth_tx_pkg::ifg_count_t     ifg_len;     // Gap length latched at gap start
    eth_tx_pkg::ifg_count_t     ifg_sel;     // Gap length decoded from link_speed
    logic                       rdy_q;       // Registered read strobe

    // Size counter stops counting once the minimum is met
    assign size_next = (size_cnt < 6'(`ETH_MIN_FRAME)) ? size_cnt + 6'd1 : size_cnt;
    assign size_done = (size_cnt >= 6'(`ETH_MIN_FRAME - 1));  // 60th byte or later

    // Strobe only in cycles that actually advance
    assign payload_ready = rdy_q & phy_ready;

    // Gap length per link speed is 96 bit times at 125 MHz
    always_comb begin
        case (link_speed)
            2'b00:   ifg_sel = `ETH_IFG_10M;
            2'b01:   ifg_sel = `ETH_IFG_100M;
            default: ifg_sel = `ETH_IFG_GBIT;   // 10 and 11 both gigabit
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer issuing one slot per advancing cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= eth_tx_pkg::IDLE;
            slot     <= '0;
            rdy_q    <= 1'b0;
            byte_cnt <= '0;
            size_cnt <= '0;
            ifg_cnt  <= '0;
            ifg_len  <= `ETH_IFG_GBIT;
        end else if (phy_ready) begin        // Everything holds under back-pressure
            slot  <= '0;                     // Idle slot unless a state fills it
            rdy_q <= 1'b0;

            case (state)
                eth_tx_pkg::IDLE: begin
                    if (payload_valid) begin
                        // First preamble byte goes out on the start edge
                        slot.valid <= 1'b1;
                        slot.data  <= `ETH_PREAMBLE_BYTE;
                        byte_cnt   <= 3'd1;
                        size_cnt   <= '0;
                        state      <= eth_tx_pkg::PREAMBLE;
                    end
                end

                eth_tx_pkg::PREAMBLE: begin
                    slot.valid <= 1'b1;
                    byte_cnt   <= byte_cnt + 3'd1;
                    if (byte_cnt == 3'd7) begin
                        // CRC restarts on the delimiter slot
                        slot.sof  <= 1'b1;
                        slot.data <= `ETH_SFD_BYTE;
                        rdy_q     <= 1'b1;   // Source byte read in next cycle
                        state     <= eth_tx_pkg::PAYLOAD;
                    end else begin
                        slot.data <= `ETH_PREAMBLE_BYTE;
                    end
                end

                eth_tx_pkg::PAYLOAD: begin
                    slot.valid  <= 1'b1;
                    slot.crc_en <= 1'b1;
                    slot.data   <= payload_data;  // Consumed by this strobe
                    size_cnt    <= size_next;
                    if (payload_last) begin
                        byte_cnt <= '0;
                        // Short packet gets zero fill first
                        if (size_done) begin
                            state <= eth_tx_pkg::FCS;
                        end else begin
                            state <= eth_tx_pkg::PADDING;
                        end
                    end else begin
                        rdy_q <= 1'b1;       // Keep reading
                    end
                end

                eth_tx_pkg::PADDING: begin
                    slot.valid  <= 1'b1;
                    slot.crc_en <= 1'b1;    // Pad bytes are covered by the FCS
                    slot.data   <= `ETH_PAD_BYTE;
                    size_cnt    <= size_next;
                    if (size_done) begin
                        byte_cnt <= '0;
                        state    <= eth_tx_pkg::FCS;
                    end
                end

                eth_tx_pkg::FCS: begin
                    // CRC register is final one cycle after the last data slot,
                    // so the output stage picks the bytes from fcs directly
                    slot.valid   <= 1'b1;
                    slot.is_fcs  <= 1'b1;
                    slot.fcs_idx <= byte_cnt[1:0];
                    byte_cnt     <= byte_cnt + 3'd1;
                    if (byte_cnt == 3'd3) begin
                        ifg_cnt <= '0;
                        ifg_len <= ifg_sel;  // Speed sampled at gap start
                        state   <= eth_tx_pkg::GAP;
                    end
                end

                eth_tx_pkg::GAP: begin
                    ifg_cnt <= ifg_cnt + 11'd1;
                    if (ifg_cnt == ifg_len - 11'd1) begin
                        state <= eth_tx_pkg::IDLE;   // Next frame may start
                    end
                end

                default: begin
                    state <= eth_tx_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Source holds payload_valid through a whole packet
    a_payload_held: assert property (
        @(posedge clk) disable iff (reset_n)
        (state == eth_tx_pkg::PAYLOAD) |-> payload_valid
    ) else $error("payload_valid fell in the middle of a packet");

    // A stalled payload byte stays in place until its strobe takes it
    a_source_hold: assert property (
        @(posedge clk) disable iff (reset_n)
        (state == eth_tx_pkg::PAYLOAD && !payload_ready)
            |=> $stable({payload_data, payload_last})
    ) else $error("payload byte changed while the PHY side stalled");

endmodule

// File: verilog/eth_tx_out_stage.sv
module eth_tx_out_stage (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    phy_ready,
    input  eth_tx_pkg::tx_slot_t    slot,
    input  eth_tx_pkg::crc_t        fcs,
    output eth_tx_pkg::eth_byte_t   tx_data,
    output logic                    tx_dv
);

    ////////////////////////////////////////////////////////////////////////////
    // Byte select
    ////////////////////////////////////////////////////////////////////////////

    eth_tx_pkg::eth_byte_t fcs_byte;   // FCS byte picked by fcs_idx
    eth_tx_pkg::eth_byte_t out_byte;   // Byte for the next PHY register load

    assign fcs_byte = fcs[8*slot.fcs_idx +: 8];  // LSB byte leaves first

    always_comb begin
        if (!slot.valid) begin
            out_byte = '0;               // Bus reads zero between frames
        end else if (slot.is_fcs) begin
            out_byte = fcs_byte;
        end else begin
            out_byte = slot.data;        // Preamble, SFD, payload or pad
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // PHY output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            tx_data <= '0;
            tx_dv   <= 1'b0;
        end else if (phy_ready) begin    // Hold bus while PHY not ready
            tx_data <= out_byte;
            tx_dv   <= slot.valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Later FCS bytes must follow a byte still on the bus, so the
    // framer's FCS run and the output register stay back to back
    a_fcs_contiguous: assert property (
        @(posedge clk) disable iff (reset_n)
        (slot.valid && slot.is_fcs && (slot.fcs_idx != 2'd0)) |-> tx_dv
    ) else $error("tx_dv low inside the FCS sequence");

endmodule

// File: verilog/eth_tx_pkg.sv
package eth_tx_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths fixed by the Ethernet standard
    ////////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  eth_byte_t;      // One octet on the byte bus
    typedef logic [31:0] crc_t;           // Running CRC and final FCS
    typedef logic [10:0] ifg_count_t;     // Gap counter, up to 1200 clocks

    // Link speed code
    // 00 -> 10 Mb/s, 01 -> 100 Mb/s, 1x -> 1 Gb/s
    typedef logic [1:0]  link_speed_t;

    ////////////////////////////////////////////////////////////////////////
    // One output byte slot, framer to CRC and output stage
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;    // Slot carries a frame byte
        logic      sof;      // Delimiter slot, CRC restarts here
        logic      crc_en;   // Payload or pad byte, folded into CRC
        logic      is_fcs;   // Take byte from FCS instead of data
        logic [1:0] fcs_idx; // FCS byte number, 0 goes out first
        eth_byte_t data;     // Byte for non-FCS slots
    } tx_slot_t;

    // Frame sequencer states
    typedef enum logic [2:0] {
        IDLE,       // Waiting for payload_valid
        PREAMBLE,   // 7x 0x55 then SFD
        PAYLOAD,    // Bytes from the source
        PADDING,    // Zero fill to the minimum
        FCS,        // Four CRC bytes
        GAP         // Inter-frame gap, no valid slots
    } framer_state_e;

endpackage

// File: verilog/eth_tx_top.sv
module eth_tx_top (
    input  logic                      clk,
    input  logic                      reset_n,

    // Byte source
    input  eth_tx_pkg::eth_byte_t     payload_data,
    input  logic                      payload_valid,
    input  logic                      payload_last,
    output logic                      payload_ready,

    // PHY byte bus
    input  logic                      phy_ready,
    output eth_tx_pkg::eth_byte_t     tx_data,
    output logic                      tx_dv,

    // Configuration
    input  eth_tx_pkg::link_speed_t   link_speed
);

    eth_tx_pkg::tx_slot_t slot;   // Framer slot, shared by CRC and output stage
    eth_tx_pkg::crc_t     fcs;    // Complemented CRC

    // Frame sequencer
    eth_tx_framer eth_tx_framer_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_last  (payload_last),
        .phy_ready     (phy_ready),
        .link_speed    (link_speed),
        .payload_ready (payload_ready),
        .slot          (slot)
    );

    // CRC runs on the same slots, in parallel
    eth_crc32 eth_crc32_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .phy_ready (phy_ready),
        .slot      (slot),
        .fcs       (fcs)
    );

    // Data/FCS mux and PHY registers
    eth_tx_out_stage eth_tx_out_stage_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .phy_ready (phy_ready),
        .slot      (slot),
        .fcs       (fcs),
        .tx_data   (tx_data),
        .tx_dv     (tx_dv)
    );

endmodule
